//--- rp_pkg.sv
// shared package for the acquisition data path and register side
// holds bus geometry, region map, register offsets and sample type
`default_nettype none

package rp_pkg;

  ////////////////////
  // adc capture
  ////////////////////
  localparam int ADC_CH   = 4;   // channels
  localparam int ADC_PINS = 7;   // ddr pins per channel
  localparam int ADC_DW   = 14;  // sample width

  typedef logic signed [ADC_DW-1:0] adc_sample_t;  // two's complement sample

  ////////////////////
  // system bus
  ////////////////////
  localparam int BUS_AW     = 32;
  localparam int BUS_DW     = 32;
  localparam int REGION_LSB = 20;  // region field starts here
  localparam int REGION_N   = 8;
  localparam int REGION_HK  = 0;   // housekeeping
  localparam int REGION_AMS = 4;   // analog outputs
  localparam int OFS_W      = 20;  // offset inside a region

  // housekeeping map
  localparam logic [OFS_W-1:0]  HK_ID_OFS  = 20'h00000;
  localparam logic [OFS_W-1:0]  HK_LED_OFS = 20'h00030;
  localparam logic [BUS_DW-1:0] HK_ID      = 32'h0a1d_0004;  // board id word
  localparam int                LED_W      = 8;

  ////////////////////
  // pdm outputs
  ////////////////////
  localparam int                PDM_CH       = 4;
  localparam int                PDM_W        = 8;
  localparam logic [PDM_W-1:0]  PDM_RANGE    = 8'd255;      // fixed period
  localparam logic [OFS_W-1:0]  PDM_OFS_BASE = 20'h00020;   // duty 0, then +4 each

endpackage

`default_nettype wire

//--- adc_deserializer.sv
// adc deserializer
// merges rise/fall pin bits into 14-bit words per channel and converts the
// negative-slope offset code to two's complement, two register stages
`timescale 1ns/1ps
`default_nettype none

module adc_deserializer (
  input  wire logic                                            adc_clk_01,
  input  wire logic                                            arst_n_i,
  input  wire logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_rise_i, // odd bits
  input  wire logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_fall_i, // even bits
  output      rp_pkg::adc_sample_t [rp_pkg::ADC_CH-1:0]        adc_dat_o
);

  logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_DW-1:0] raw;     // interleaved raw code
  rp_pkg::adc_sample_t [rp_pkg::ADC_CH-1:0]        conv_q;  // first stage

  ////////////////////
  // bit interleave
  ////////////////////
  always_comb begin
    for (int ch = 0; ch < rp_pkg::ADC_CH; ch++) begin
      for (int k = 0; k < rp_pkg::ADC_PINS; k++) begin
        raw[ch][2*k]   = adc_fall_i[ch][k];  // falling edge -> even
        raw[ch][2*k+1] = adc_rise_i[ch][k];  // rising edge -> odd
      end
    end
  end

  ////////////////////
  // code conversion + pipeline
  ////////////////////
  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      conv_q    <= '0;
      adc_dat_o <= '0;
    end else begin
      for (int ch = 0; ch < rp_pkg::ADC_CH; ch++) begin
        // keep msb, flip the rest
        conv_q[ch] <= {raw[ch][rp_pkg::ADC_DW-1], ~raw[ch][rp_pkg::ADC_DW-2:0]};
      end
      adc_dat_o <= conv_q;  // second stage
    end
  end

endmodule

`default_nettype wire

//--- sys_bus_decoder.sv
// system bus decoder
// splits the strobe/ack bus into eight regions, routes strobes to the two
// live slaves, muxes their replies and answers empty regions with an error
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  wire logic                         adc_clk_01,
  input  wire logic                         arst_n_i,
  // master side
  input  wire logic [rp_pkg::BUS_AW-1:0]    sys_addr_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]    sys_wdata_i,
  input  wire logic                         sys_wen_i,
  input  wire logic                         sys_ren_i,
  output      logic [rp_pkg::BUS_DW-1:0]    sys_rdata_o,
  output      logic                         sys_ack_o,
  output      logic                         sys_err_o,
  // shared to slaves
  output      logic [rp_pkg::OFS_W-1:0]     ofs_o,
  output      logic [rp_pkg::BUS_DW-1:0]    wdata_o,
  // housekeeping
  output      logic                         hk_wen_o,
  output      logic                         hk_ren_o,
  input  wire logic [rp_pkg::BUS_DW-1:0]    hk_rdata_i,
  input  wire logic                         hk_ack_i,
  // analog outputs
  output      logic                         ams_wen_o,
  output      logic                         ams_ren_o,
  input  wire logic [rp_pkg::BUS_DW-1:0]    ams_rdata_i,
  input  wire logic                         ams_ack_i
);

  logic [$clog2(rp_pkg::REGION_N)-1:0] region;    // current region
  logic [$clog2(rp_pkg::REGION_N)-1:0] region_q;  // region of pending access
  logic                                strobe;
  logic                                sel_hk;
  logic                                sel_ams;
  logic                                stub_q;    // empty region hit

  assign region  = sys_addr_i[rp_pkg::REGION_LSB +: $clog2(rp_pkg::REGION_N)];
  assign strobe  = sys_wen_i | sys_ren_i;
  assign sel_hk  = (region == rp_pkg::REGION_HK);
  assign sel_ams = (region == rp_pkg::REGION_AMS);

  ////////////////////
  // request routing
  ////////////////////
  assign ofs_o     = sys_addr_i[rp_pkg::OFS_W-1:0];
  assign wdata_o   = sys_wdata_i;
  assign hk_wen_o  = sys_wen_i & sel_hk;
  assign hk_ren_o  = sys_ren_i & sel_hk;
  assign ams_wen_o = sys_wen_i & sel_ams;
  assign ams_ren_o = sys_ren_i & sel_ams;

  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      region_q <= '0;
      stub_q   <= 1'b0;
    end else begin
      if (strobe) region_q <= region;     // hold for the reply mux
      stub_q <= strobe & ~sel_hk & ~sel_ams;
    end
  end

  ////////////////////
  // reply mux
  ////////////////////
  always_comb begin
    sys_rdata_o = '0;  // also the answer for empty regions
    sys_ack_o   = stub_q;
    if (region_q == rp_pkg::REGION_HK && hk_ack_i) begin
      sys_rdata_o = hk_rdata_i;
      sys_ack_o   = 1'b1;
    end else if (region_q == rp_pkg::REGION_AMS && ams_ack_i) begin
      sys_rdata_o = ams_rdata_i;
      sys_ack_o   = 1'b1;
    end
  end

  assign sys_err_o = stub_q;

  // master never strobes both ways at once
  a_no_dual_strobe: assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i));

  // every ack, from a slave or from here, answers the strobe one cycle before
  a_ack_after_strobe: assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule

`default_nettype wire

//--- hk_regs.sv
// housekeeping slave
// read-only id word plus the led register
`timescale 1ns/1ps
`default_nettype none

module hk_regs (
  input  wire logic                         adc_clk_01,
  input  wire logic                         arst_n_i,
  input  wire logic [rp_pkg::OFS_W-1:0]     ofs_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]    wdata_i,
  input  wire logic                         wen_i,
  input  wire logic                         ren_i,
  output      logic [rp_pkg::BUS_DW-1:0]    rdata_o,
  output      logic                         ack_o,
  output      logic [rp_pkg::LED_W-1:0]     led_o
);

  logic [rp_pkg::BUS_DW-1:0] rd_val;  // read data for current offset

  // led register, other offsets ignore writes
  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_o <= '0;
      ack_o <= 1'b0;
    end else begin
      if (wen_i && ofs_i == rp_pkg::HK_LED_OFS) led_o <= wdata_i[rp_pkg::LED_W-1:0];
      ack_o <= wen_i | ren_i;  // reply next cycle
    end
  end

  always_comb begin
    case (ofs_i)
      rp_pkg::HK_ID_OFS:  rd_val = rp_pkg::HK_ID;
      rp_pkg::HK_LED_OFS: rd_val = {{(rp_pkg::BUS_DW-rp_pkg::LED_W){1'b0}}, led_o};
      default:            rd_val = '0;  // unmapped reads as zero
    endcase
  end

  // read data, zero on writes
  always_ff @(posedge adc_clk_01) begin
    if (wen_i || ren_i) rdata_o <= ren_i ? rd_val : '0;
  end

endmodule

`default_nettype wire

//--- pdm_regs.sv
// analog-output config slave
// four 8-bit pdm duty registers, one bus word apart
`timescale 1ns/1ps
`default_nettype none

module pdm_regs (
  input  wire logic                                          adc_clk_01,
  input  wire logic                                          arst_n_i,
  input  wire logic [rp_pkg::OFS_W-1:0]                      ofs_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]                     wdata_i,
  input  wire logic                                          wen_i,
  input  wire logic                                          ren_i,
  output      logic [rp_pkg::BUS_DW-1:0]                     rdata_o,
  output      logic                                          ack_o,
  output      logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0]  duty_o
);

  logic [rp_pkg::PDM_CH-1:0] hit;     // offset matches duty reg i
  logic [rp_pkg::BUS_DW-1:0] rd_val;

  ////////////////////
  // address decode
  ////////////////////
  always_comb begin
    for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
      hit[i] = (ofs_i == rp_pkg::PDM_OFS_BASE + 4*i);  // word spacing
    end
  end

  always_comb begin
    rd_val = '0;  // unmapped offsets read zero
    for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
      if (hit[i]) rd_val = {{(rp_pkg::BUS_DW-rp_pkg::PDM_W){1'b0}}, duty_o[i]};
    end
  end

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      duty_o <= '0;
      ack_o  <= 1'b0;
    end else begin
      for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
        if (wen_i && hit[i]) duty_o[i] <= wdata_i[rp_pkg::PDM_W-1:0];  // low byte only
      end
      ack_o <= wen_i | ren_i;
    end
  end

  // read data, captured with the strobe
  always_ff @(posedge adc_clk_01) begin
    if (wen_i || ren_i) rdata_o <= ren_i ? rd_val : '0;
  end

endmodule

`default_nettype wire

//--- pdm_modulator.sv
// pdm modulator
// per channel accumulator, emits a one each time the sum wraps past the
// fixed range, so ones per 255 cycles equal the duty value
`timescale 1ns/1ps
`default_nettype none

module pdm_modulator (
  input  wire logic                                          adc_clk_01,
  input  wire logic                                          arst_n_i,
  input  wire logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0]  duty_i,
  output      logic [rp_pkg::PDM_CH-1:0]                     pdm_o
);

  for (genvar g = 0; g < rp_pkg::PDM_CH; g++) begin : g_ch
    logic [rp_pkg::PDM_W-1:0] acc_q;  // residue, always below range
    logic [rp_pkg::PDM_W:0]   sum;    // one carry bit
    logic [rp_pkg::PDM_W:0]   rem;    // sum minus range

    assign sum = {1'b0, acc_q} + {1'b0, duty_i[g]};
    assign rem = sum - {1'b0, rp_pkg::PDM_RANGE};

    always_ff @(posedge adc_clk_01 or negedge arst_n_i) begin
      if (!arst_n_i) begin
        acc_q    <= '0;
        pdm_o[g] <= 1'b0;
      end else if (sum >= {1'b0, rp_pkg::PDM_RANGE}) begin
        acc_q    <= rem[rp_pkg::PDM_W-1:0];  // wrap
        pdm_o[g] <= 1'b1;
      end else begin
        acc_q    <= sum[rp_pkg::PDM_W-1:0];
        pdm_o[g] <= 1'b0;
      end
    end

    // residue must stay in range across cycles, else density drifts
    a_acc_range: assert property (@(posedge adc_clk_01) disable iff (!arst_n_i)
      acc_q < rp_pkg::PDM_RANGE);
  end

endmodule

`default_nettype wire

//--- analog_top.sv
// analog top
// adc capture, system bus decoder, housekeeping and pdm slaves, pdm outputs
`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  wire logic                                            adc_clk_01,
  input  wire logic                                            arst_n_i,
  // adc
  input  wire logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_rise_i,
  input  wire logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_fall_i,
  output      rp_pkg::adc_sample_t [rp_pkg::ADC_CH-1:0]        adc_dat_o,
  // system bus
  input  wire logic [rp_pkg::BUS_AW-1:0]                       sys_addr_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]                       sys_wdata_i,
  input  wire logic                                            sys_wen_i,
  input  wire logic                                            sys_ren_i,
  output      logic [rp_pkg::BUS_DW-1:0]                       sys_rdata_o,
  output      logic                                            sys_ack_o,
  output      logic                                            sys_err_o,
  // board outputs
  output      logic [rp_pkg::LED_W-1:0]                        led_o,
  output      logic [rp_pkg::PDM_CH-1:0]                       dac_pwm_o
);

  logic [rp_pkg::OFS_W-1:0]                      ofs;
  logic [rp_pkg::BUS_DW-1:0]                     wdata;
  logic                                          hk_wen, hk_ren, hk_ack;
  logic [rp_pkg::BUS_DW-1:0]                     hk_rdata;
  logic                                          ams_wen, ams_ren, ams_ack;
  logic [rp_pkg::BUS_DW-1:0]                     ams_rdata;
  logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0]  pdm_duty;  // regs -> modulator

  ////////////////////
  // adc capture
  ////////////////////
  adc_deserializer i_adc (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .adc_rise_i (adc_rise_i), .adc_fall_i (adc_fall_i),
    .adc_dat_o  (adc_dat_o)
  );

  ////////////////////
  // bus + slaves
  ////////////////////
  sys_bus_decoder i_dec (
    .adc_clk_01  (adc_clk_01),  .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .ofs_o       (ofs),         .wdata_o     (wdata),
    .hk_wen_o    (hk_wen),      .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i    (hk_ack),
    .ams_wen_o   (ams_wen),     .ams_ren_o   (ams_ren),
    .ams_rdata_i (ams_rdata),   .ams_ack_i   (ams_ack)
  );

  hk_regs i_hk (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .ofs_i      (ofs),        .wdata_i  (wdata),
    .wen_i      (hk_wen),     .ren_i    (hk_ren),
    .rdata_o    (hk_rdata),   .ack_o    (hk_ack),
    .led_o      (led_o)
  );

  pdm_regs i_ams (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .ofs_i      (ofs),        .wdata_i  (wdata),
    .wen_i      (ams_wen),    .ren_i    (ams_ren),
    .rdata_o    (ams_rdata),  .ack_o    (ams_ack),
    .duty_o     (pdm_duty)
  );

  // pdm analog outputs
  pdm_modulator i_pdm (
    .adc_clk_01 (adc_clk_01), .arst_n_i (arst_n_i),
    .duty_i     (pdm_duty),   .pdm_o    (dac_pwm_o)
  );

endmodule

`default_nettype wire

//--- tb_analog_top.sv
// testbench for analog top
// checks adc capture against a reference model, the register slaves,
// pdm density per 255-cycle window and error replies from empty regions
`timescale 1ns/1ps
`default_nettype none

module tb_analog_top;

  localparam int CLK_HALF_NS    = 20;   // 40 ns period
  localparam int RESET_CYCLES   = 16;
  localparam int CAPTURE_N      = 200;  // random capture words
  localparam int ACK_WAIT       = 8;    // cycles allowed for an ack
  // reset + capture + ~60 bus accesses of 3 cycles + four pdm windows, doubled
  localparam int TIMEOUT_CYCLES = 4000;

  logic                                            adc_clk_01;
  logic                                            arst_n_i;
  logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_rise_i;
  logic [rp_pkg::ADC_CH-1:0][rp_pkg::ADC_PINS-1:0] adc_fall_i;
  rp_pkg::adc_sample_t [rp_pkg::ADC_CH-1:0]        adc_dat_o;
  logic [rp_pkg::BUS_AW-1:0]                       sys_addr_i;
  logic [rp_pkg::BUS_DW-1:0]                       sys_wdata_i;
  logic                                            sys_wen_i;
  logic                                            sys_ren_i;
  logic [rp_pkg::BUS_DW-1:0]                       sys_rdata_o;
  logic                                            sys_ack_o;
  logic                                            sys_err_o;
  logic [rp_pkg::LED_W-1:0]                        led_o;
  logic [rp_pkg::PDM_CH-1:0]                       dac_pwm_o;

  integer                                          seed;
  int                                              cycles;
  logic                                            cap_on;   // capture compare enable
  logic                                            cap_d1, cap_d2;
  rp_pkg::adc_sample_t                             exp_d1 [rp_pkg::ADC_CH];
  rp_pkg::adc_sample_t                             exp_d2 [rp_pkg::ADC_CH];

  analog_top i_analog_top (
    .adc_clk_01 (adc_clk_01), .arst_n_i    (arst_n_i),
    .adc_rise_i (adc_rise_i), .adc_fall_i  (adc_fall_i),
    .adc_dat_o  (adc_dat_o),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i  (sys_wen_i),  .sys_ren_i   (sys_ren_i),
    .sys_rdata_o(sys_rdata_o), .sys_ack_o  (sys_ack_o),
    .sys_err_o  (sys_err_o),
    .led_o      (led_o),      .dac_pwm_o   (dac_pwm_o)
  );

  always #(CLK_HALF_NS) adc_clk_01 = ~adc_clk_01;

  ////////////////////
  // reference model
  ////////////////////
  // fall bit k -> raw 2k, rise bit k -> raw 2k+1, then flip all but the msb
  function automatic rp_pkg::adc_sample_t expected_sample(
    input logic [rp_pkg::ADC_PINS-1:0] rise,
    input logic [rp_pkg::ADC_PINS-1:0] fall
  );
    logic [rp_pkg::ADC_DW-1:0] raw;
    for (int k = 0; k < rp_pkg::ADC_PINS; k++) begin
      raw[2*k]   = fall[k];
      raw[2*k+1] = rise[k];
    end
    return {raw[rp_pkg::ADC_DW-1], ~raw[rp_pkg::ADC_DW-2:0]};
  endfunction

  function automatic logic [rp_pkg::BUS_AW-1:0] make_addr(
    input int                       region,
    input logic [rp_pkg::OFS_W-1:0] ofs
  );
    return (rp_pkg::BUS_AW'(region) << rp_pkg::REGION_LSB) |
           {{(rp_pkg::BUS_AW-rp_pkg::OFS_W){1'b0}}, ofs};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  ////////////////////
  // bus master
  ////////////////////
  task automatic wait_ack(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    int n;
    n = 0;
    do begin
      @(negedge adc_clk_01);  // ack cycle is stable here
      n++;
    end while (sys_ack_o !== 1'b1 && n < ACK_WAIT);
    if (sys_ack_o !== 1'b1) begin
      $display("no bus acknowledge for address 0x%08h within %0d cycles", addr, ACK_WAIT);
      $display("Checks failed");
      $fatal(1, "bus hung");
    end else begin
      rdata = sys_rdata_o;
      err   = sys_err_o;
      check_value("sys_ack_o latency", n, 32'd1);  // reply one cycle after strobe
      @(negedge adc_clk_01);
      check_value("sys_ack_o", {31'h0, sys_ack_o}, 32'h0);  // single-cycle pulse
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rd;
    @(posedge adc_clk_01);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk_01);
    sys_wen_i   <= 1'b0;  // single-cycle strobe
    wait_ack(addr, unused_rd, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge adc_clk_01);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk_01);
    sys_ren_i  <= 1'b0;
    wait_ack(addr, data, err);
  endtask

  // read all duty regs back, expect the given values zero-extended
  task automatic check_duties(input logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0] exp);
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
      bus_read(make_addr(rp_pkg::REGION_AMS, rp_pkg::PDM_OFS_BASE + 20'(4*i)), rd, err);
      check_value($sformatf("duty[%0d] read", i), rd, {24'h0, exp[i]});
      check_value("sys_err_o", {31'h0, err}, 32'h0);
    end
  endtask

  // write duties, settle, then count ones over one full modulator range
  task automatic pdm_window(input logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0] duty);
    logic        err;
    int          ones [rp_pkg::PDM_CH];
    for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
      bus_write(make_addr(rp_pkg::REGION_AMS, rp_pkg::PDM_OFS_BASE + 20'(4*i)),
                {$random(seed)} & 32'hffff_ff00 | {24'h0, duty[i]}, err);  // junk upper bits
      check_value("sys_err_o", {31'h0, err}, 32'h0);
      ones[i] = 0;
    end
    repeat (4) @(negedge adc_clk_01);
    repeat (int'(rp_pkg::PDM_RANGE)) begin
      @(negedge adc_clk_01);
      for (int i = 0; i < rp_pkg::PDM_CH; i++) ones[i] += int'(dac_pwm_o[i]);
    end
    for (int i = 0; i < rp_pkg::PDM_CH; i++) begin
      check_value($sformatf("dac_pwm_o[%0d] ones", i), ones[i], {24'h0, duty[i]});
    end
  endtask

  ////////////////////
  // capture compare
  ////////////////////
  always @(negedge adc_clk_01) begin
    if (cap_d2) begin
      for (int ch = 0; ch < rp_pkg::ADC_CH; ch++) begin
        check_value($sformatf("adc_dat_o[%0d]", ch), 32'(adc_dat_o[ch]), 32'(exp_d2[ch]));
      end
    end
    exp_d2 = exp_d1;  // two-stage delay line, matches the pipeline
    cap_d2 = cap_d1;
    cap_d1 = cap_on;
    for (int ch = 0; ch < rp_pkg::ADC_CH; ch++) begin
      exp_d1[ch] = expected_sample(adc_rise_i[ch], adc_fall_i[ch]);
    end
  end

  // watchdog
  always @(posedge adc_clk_01) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    logic [31:0]                                   rd;
    logic                                          err;
    logic [rp_pkg::LED_W-1:0]                      led_val;
    logic [rp_pkg::PDM_CH-1:0][rp_pkg::PDM_W-1:0]  duty;
    logic [31:0]                                   rnd;
    seed        = 32'h50a2_13eb;
    cycles      = 0;
    adc_clk_01  = 1'b0;
    arst_n_i    = 1'b0;
    adc_rise_i  = '0;
    adc_fall_i  = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    cap_on      = 1'b0;
    cap_d1      = 1'b0;
    cap_d2      = 1'b0;
    repeat (RESET_CYCLES) @(posedge adc_clk_01);
    arst_n_i <= 1'b1;

    // reset state
    @(negedge adc_clk_01);
    check_value("led_o", {24'h0, led_o}, 32'h0);
    check_value("dac_pwm_o", {28'h0, dac_pwm_o}, 32'h0);
    check_value("sys_ack_o", {31'h0, sys_ack_o}, 32'h0);
    check_value("sys_err_o", {31'h0, sys_err_o}, 32'h0);
    check_duties('0);

    // housekeeping: id word and led
    bus_read(make_addr(rp_pkg::REGION_HK, rp_pkg::HK_ID_OFS), rd, err);
    check_value("hk id read", rd, 32'h0a1d_0004);
    check_value("sys_err_o", {31'h0, err}, 32'h0);
    rnd     = $random(seed);
    led_val = rnd[7:0];
    bus_write(make_addr(rp_pkg::REGION_HK, rp_pkg::HK_LED_OFS), rnd, err);
    check_value("sys_err_o", {31'h0, err}, 32'h0);
    check_value("led_o", {24'h0, led_o}, {24'h0, led_val});
    bus_read(make_addr(rp_pkg::REGION_HK, rp_pkg::HK_LED_OFS), rd, err);
    check_value("led read", rd, {24'h0, led_val});

    // pdm windows, first round also covers duty read-back
    rnd = $random(seed);
    pdm_window(rnd);
    check_duties(rnd);
    pdm_window('0);
    pdm_window({rp_pkg::PDM_CH{8'hff}});
    rnd  = $random(seed);
    duty = rnd;
    pdm_window(duty);

    // empty regions answer with err, state untouched
    for (int r = 0; r < rp_pkg::REGION_N; r++) begin
      if (r != rp_pkg::REGION_HK && r != rp_pkg::REGION_AMS) begin
        bus_write(make_addr(r, rp_pkg::HK_LED_OFS), $random(seed), err);
        check_value($sformatf("sys_err_o wr region %0d", r), {31'h0, err}, 32'h1);
        bus_write(make_addr(r, rp_pkg::PDM_OFS_BASE), $random(seed), err);
        check_value($sformatf("sys_err_o wr region %0d", r), {31'h0, err}, 32'h1);
        bus_read(make_addr(r, rp_pkg::HK_LED_OFS), rd, err);
        check_value($sformatf("sys_err_o rd region %0d", r), {31'h0, err}, 32'h1);
        check_value($sformatf("sys_rdata_o region %0d", r), rd, 32'h0);
      end
    end
    check_value("led_o", {24'h0, led_o}, {24'h0, led_val});
    check_duties(duty);

    // adc capture, one new word per cycle
    for (int i = 0; i < CAPTURE_N; i++) begin
      @(posedge adc_clk_01);
      rnd = $random(seed);
      adc_rise_i <= rnd[27:0];
      rnd = $random(seed);
      adc_fall_i <= rnd[27:0];
      cap_on     <= 1'b1;
    end
    @(posedge adc_clk_01);
    cap_on <= 1'b0;
    repeat (4) @(posedge adc_clk_01);  // drain the pipeline compare

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rp_pkg.sv
adc_deserializer.sv
sys_bus_decoder.sv
hk_regs.sv
pdm_regs.sv
pdm_modulator.sv
analog_top.sv
tb_analog_top.sv

//--- Makefile
# Verilator simulation of the acquisition data path
VERILATOR ?= verilator
TOP       ?= tb_analog_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
